// ==== hdl/cfg_ctrl_pkg.sv ====
package cfg_ctrl_pkg;

	//////////////////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////////////////
	localparam int DATA_W     = 32;
	localparam int ADDR_W     = 32;
	localparam int MST_ADDR_W = 15;    // Low address bits seen by subsystems
	localparam int LOC_ADDR_W = 12;    // Offset inside one 4 KB page
	localparam int PAGE_W     = 20;
	localparam int STRB_W     = 4;
	localparam int PRJ_SEL_W  = 5;

	//////////////////////////////////////////////////////////////
	// Page map, address bits 31:12
	//////////////////////////////////////////////////////////////
	localparam logic [PAGE_W-1:0] PAGE_UP  = 20'h30000;    // User project
	localparam logic [PAGE_W-1:0] PAGE_LA  = 20'h30001;    // Logic analyzer
	localparam logic [PAGE_W-1:0] PAGE_AA  = 20'h30002;    // Axis-axilite
	localparam logic [PAGE_W-1:0] PAGE_IS  = 20'h30003;    // IO serdes
	localparam logic [PAGE_W-1:0] PAGE_LOC = 20'h30004;    // Local registers

	// Writes complete and reads return all ones in this range
	localparam logic [PAGE_W-1:0] PAGE_UNMAP_FIRST = 20'h30005;
	localparam logic [PAGE_W-1:0] PAGE_UNMAP_LAST  = 20'h3FFFF;

	localparam logic [DATA_W-1:0] UNMAPPED_RDATA = '1;
	localparam logic [STRB_W-1:0] FULL_STRB      = '1;

	//////////////////////////////////////////////////////////////
	// Structs
	//////////////////////////////////////////////////////////////
	// Front end to master
	typedef struct packed {
		logic              req;
		logic              rw;       // 1 = write
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
	} cfg_req_t;

	// AXI-Lite master outputs
	typedef struct packed {
		logic                  awvalid;
		logic [MST_ADDR_W-1:0] awaddr;
		logic                  wvalid;
		logic [DATA_W-1:0]     wdata;
		logic [STRB_W-1:0]     wstrb;
		logic                  arvalid;
		logic [MST_ADDR_W-1:0] araddr;
		logic                  rready;
	} axil_mst_t;

	// One slave's answer, no B channel
	typedef struct packed {
		logic              awready;
		logic              wready;
		logic              arready;
		logic [DATA_W-1:0] rdata;
		logic              rvalid;
	} axil_rsp_t;

	typedef struct packed {
		logic up;
		logic la;
		logic aa;
		logic is;
		logic loc;
		logic unmap;
	} cfg_sel_t;

	//////////////////////////////////////////////////////////////
	// FSM states
	//////////////////////////////////////////////////////////////
	typedef enum logic [2:0] {
		FE_IDLE, FE_RD_WAIT, FE_RD_HOLD, FE_WR_DATA, FE_WR_WAIT
	} front_state_e;

	typedef enum logic [2:0] {
		MS_IDLE, MS_RD_ADDR, MS_RD_DATA, MS_WR_BOTH, MS_WR_DATA
	} mst_state_e;

	typedef enum logic [2:0] {
		LR_IDLE, LR_RD_RESP, LR_RD_HOLD, LR_WR_DATA, LR_WR_COMMIT
	} loc_state_e;

endpackage

// ==== hdl/cfg_front_end.sv ====
`timescale 1ns/1ps

module cfg_front_end
	import cfg_ctrl_pkg::*;
(
	input  logic              axi_clk,
	input  logic              axi_reset_n,

	// Configuration port
	input  logic              aa_awvalid_i,
	input  logic [ADDR_W-1:0] aa_awaddr_i,
	input  logic              aa_wvalid_i,
	input  logic [DATA_W-1:0] aa_wdata_i,
	input  logic              aa_arvalid_i,
	input  logic [ADDR_W-1:0] aa_araddr_i,
	input  logic              aa_rready_i,
	output logic              aa_awready_o,
	output logic              aa_wready_o,
	output logic              aa_arready_o,
	output logic [DATA_W-1:0] aa_rdata_o,
	output logic              aa_rvalid_o,

	// Request to the master
	output cfg_req_t          req_o,
	input  logic              done_i,
	input  logic [DATA_W-1:0] rdata_i
);

	front_state_e state;

	//////////////////////////////////////////////////////////////
	// Port FSM
	//////////////////////////////////////////////////////////////
	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			state        <= FE_IDLE;
			req_o        <= '0;
			aa_awready_o <= 1'b0;
			aa_wready_o  <= 1'b0;
			aa_arready_o <= 1'b0;
			aa_rdata_o   <= '0;
			aa_rvalid_o  <= 1'b0;
		end else begin
			case (state)
				FE_IDLE: begin
					aa_wready_o <= 1'b0;    // End of the write completion pulse
					if (aa_awvalid_i) begin    // Writes win a tie
						aa_awready_o <= 1'b1;
						req_o.addr   <= aa_awaddr_i;
						state        <= FE_WR_DATA;
					end else if (aa_arvalid_i) begin
						aa_arready_o <= 1'b1;
						req_o.addr   <= aa_araddr_i;
						req_o.rw     <= 1'b0;
						req_o.req    <= 1'b1;
						state        <= FE_RD_WAIT;
					end
				end
				FE_RD_WAIT: begin
					aa_arready_o <= 1'b0;
					// Request stays up while rready is held low
					if (done_i && aa_rready_i) begin
						aa_rdata_o  <= rdata_i;
						aa_rvalid_o <= 1'b1;
						req_o.req   <= 1'b0;
						req_o.addr  <= '0;
						state       <= FE_RD_HOLD;
					end
				end
				FE_RD_HOLD: begin
					if (aa_rready_i) begin
						aa_rdata_o  <= '0;
						aa_rvalid_o <= 1'b0;
						state       <= FE_IDLE;
					end
				end
				FE_WR_DATA: begin
					aa_awready_o <= 1'b0;
					if (aa_wvalid_i) begin
						req_o.wdata <= aa_wdata_i;
						req_o.rw    <= 1'b1;
						req_o.req   <= 1'b1;
						state       <= FE_WR_WAIT;
					end
				end
				FE_WR_WAIT: begin
					if (done_i) begin
						aa_wready_o <= 1'b1;    // Marks write completion
						req_o.req   <= 1'b0;
						req_o.addr  <= '0;
						state       <= FE_IDLE;
					end
				end
				default: state <= FE_IDLE;
			endcase
		end
	end

endmodule

// ==== hdl/cfg_axil_master.sv ====
`timescale 1ns/1ps

module cfg_axil_master
	import cfg_ctrl_pkg::*;
(
	input  logic              axi_clk,
	input  logic              axi_reset_n,

	input  cfg_req_t          req_i,
	output logic              done_o,
	output logic [DATA_W-1:0] rdata_o,

	output axil_mst_t         mst_o,
	input  axil_rsp_t         rsp_i
);

	mst_state_e state;
	logic       aw_ok;    // Address side finished, now or earlier
	logic       w_ok;

	assign aw_ok = rsp_i.awready || !mst_o.awvalid;
	assign w_ok  = rsp_i.wready || !mst_o.wvalid;

	//////////////////////////////////////////////////////////////
	// Master FSM
	//////////////////////////////////////////////////////////////
	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			state  <= MS_IDLE;
			done_o <= 1'b0;
			mst_o  <= '0;
		end else begin
			case (state)
				MS_IDLE: begin
					if (!req_i.req) begin
						done_o <= 1'b0;    // Request withdrawn, ready for the next
					end else if (!done_o) begin
						if (req_i.rw) begin
							mst_o.awvalid <= 1'b1;
							mst_o.awaddr  <= req_i.addr[MST_ADDR_W-1:0];
							mst_o.wvalid  <= 1'b1;
							mst_o.wdata   <= req_i.wdata;
							mst_o.wstrb   <= FULL_STRB;
							state         <= MS_WR_BOTH;
						end else begin
							mst_o.arvalid <= 1'b1;
							mst_o.araddr  <= req_i.addr[MST_ADDR_W-1:0];
							mst_o.rready  <= 1'b1;
							state         <= MS_RD_ADDR;
						end
					end
				end
				MS_RD_ADDR: begin
					if (rsp_i.arready) begin
						mst_o.arvalid <= 1'b0;
						mst_o.araddr  <= '0;
						if (rsp_i.rvalid) begin    // Data with the address ready
							mst_o.rready <= 1'b0;
							done_o       <= 1'b1;
							state        <= MS_IDLE;
						end else begin
							state <= MS_RD_DATA;
						end
					end
				end
				MS_RD_DATA: begin
					if (rsp_i.rvalid) begin
						mst_o.rready <= 1'b0;
						done_o       <= 1'b1;
						state        <= MS_IDLE;
					end
				end
				MS_WR_BOTH: begin
					if (aw_ok && w_ok) begin
						mst_o.awvalid <= 1'b0;
						mst_o.awaddr  <= '0;
						mst_o.wvalid  <= 1'b0;
						mst_o.wdata   <= '0;
						mst_o.wstrb   <= '0;
						done_o        <= 1'b1;
						state         <= MS_IDLE;
					end else if (aw_ok) begin
						mst_o.awvalid <= 1'b0;
						mst_o.awaddr  <= '0;
						state         <= MS_WR_DATA;
					end else if (w_ok) begin
						mst_o.wvalid <= 1'b0;    // Data taken first, wait for address
					end
				end
				MS_WR_DATA: begin
					if (rsp_i.wready) begin
						mst_o.wvalid <= 1'b0;
						mst_o.wdata  <= '0;
						mst_o.wstrb  <= '0;
						done_o       <= 1'b1;
						state        <= MS_IDLE;
					end
				end
				default: state <= MS_IDLE;
			endcase
		end
	end

	// Read data capture, same cycle that sets done
	always_ff @(posedge axi_clk) begin
		if (mst_o.rready && rsp_i.rvalid)
			rdata_o <= rsp_i.rdata;
	end

endmodule

// ==== hdl/cfg_target_decode.sv ====
`timescale 1ns/1ps

module cfg_target_decode
	import cfg_ctrl_pkg::*;
(
	input  logic [ADDR_W-1:0] addr_i,
	input  axil_mst_t         mst_i,
	input  axil_rsp_t         rsp_up_i,
	input  axil_rsp_t         rsp_la_i,
	input  axil_rsp_t         rsp_aa_i,
	input  axil_rsp_t         rsp_is_i,
	input  axil_rsp_t         rsp_loc_i,
	output cfg_sel_t          sel_o,
	output axil_rsp_t         rsp_o
);

	logic [PAGE_W-1:0] page;
	axil_rsp_t         rsp_unmap;

	function automatic axil_rsp_t gate(input axil_rsp_t rsp, input logic en);
		gate = rsp & {$bits(axil_rsp_t){en}};
	endfunction

	assign page = addr_i[ADDR_W-1:LOC_ADDR_W];

	//////////////////////////////////////////////////////////////
	// Page decode, at most one enable
	//////////////////////////////////////////////////////////////
	always_comb begin
		sel_o       = '0;
		sel_o.up    = (page == PAGE_UP);
		sel_o.la    = (page == PAGE_LA);
		sel_o.aa    = (page == PAGE_AA);
		sel_o.is    = (page == PAGE_IS);
		sel_o.loc   = (page == PAGE_LOC);
		sel_o.unmap = (page >= PAGE_UNMAP_FIRST) && (page <= PAGE_UNMAP_LAST);
	end

	// Unmapped responder accepts everything at once
	assign rsp_unmap = '{
		awready: mst_i.awvalid,
		wready:  mst_i.wvalid,
		arready: mst_i.arvalid,
		rdata:   UNMAPPED_RDATA,
		rvalid:  mst_i.arvalid
	};

	//////////////////////////////////////////////////////////////
	// Response mux
	//////////////////////////////////////////////////////////////
	assign rsp_o = gate(rsp_up_i, sel_o.up)
	             | gate(rsp_la_i, sel_o.la)
	             | gate(rsp_aa_i, sel_o.aa)
	             | gate(rsp_is_i, sel_o.is)
	             | gate(rsp_loc_i, sel_o.loc)
	             | gate(rsp_unmap, sel_o.unmap);

endmodule

// ==== hdl/cfg_local_regs.sv ====
`timescale 1ns/1ps

module cfg_local_regs
	import cfg_ctrl_pkg::*;
(
	input  logic                 axi_clk,
	input  logic                 axi_reset_n,
	input  logic                 enable_i,
	input  axil_mst_t            mst_i,
	output axil_rsp_t            rsp_o,
	output logic [PRJ_SEL_W-1:0] user_prj_sel_o
);

	loc_state_e            state;
	logic                  awready_q;
	logic                  wready_q;
	logic                  arready_q;
	logic                  rvalid_q;
	logic [DATA_W-1:0]     rdata_q;
	logic [LOC_ADDR_W-1:0] offset;
	logic [DATA_W-1:0]     wdata_q;

	assign rsp_o = '{
		awready: awready_q,
		wready:  wready_q,
		arready: arready_q,
		rdata:   rdata_q,
		rvalid:  rvalid_q
	};

	//////////////////////////////////////////////////////////////
	// Slave FSM
	//////////////////////////////////////////////////////////////
	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			state          <= LR_IDLE;
			awready_q      <= 1'b0;
			wready_q       <= 1'b0;
			arready_q      <= 1'b0;
			rvalid_q       <= 1'b0;
			user_prj_sel_o <= '0;
		end else if (!enable_i) begin    // Page not addressed, stay idle
			state     <= LR_IDLE;
			awready_q <= 1'b0;
			wready_q  <= 1'b0;
			arready_q <= 1'b0;
			rvalid_q  <= 1'b0;
		end else begin
			case (state)
				LR_IDLE: begin
					if (mst_i.arvalid) begin
						arready_q <= 1'b1;
						state     <= LR_RD_RESP;
					end else if (mst_i.awvalid && mst_i.wvalid) begin
						awready_q <= 1'b1;
						wready_q  <= 1'b1;
						state     <= LR_WR_COMMIT;
					end else if (mst_i.awvalid) begin
						awready_q <= 1'b1;
						state     <= LR_WR_DATA;
					end
				end
				LR_RD_RESP: begin
					arready_q <= 1'b0;
					rvalid_q  <= 1'b1;
					state     <= LR_RD_HOLD;
				end
				LR_RD_HOLD: begin
					if (mst_i.rready) begin
						rvalid_q <= 1'b0;
						state    <= LR_IDLE;
					end
				end
				LR_WR_DATA: begin
					awready_q <= 1'b0;
					if (mst_i.wvalid) begin
						wready_q <= 1'b1;
						state    <= LR_WR_COMMIT;
					end
				end
				LR_WR_COMMIT: begin
					awready_q <= 1'b0;
					wready_q  <= 1'b0;
					if (offset == '0)
						user_prj_sel_o <= wdata_q[PRJ_SEL_W-1:0];    // Other offsets dropped
					state <= LR_IDLE;
				end
				default: state <= LR_IDLE;
			endcase
		end
	end

	// Offset, write data and read data
	always_ff @(posedge axi_clk) begin
		if (state == LR_IDLE) begin
			if (mst_i.arvalid)
				offset <= mst_i.araddr[LOC_ADDR_W-1:0];
			else if (mst_i.awvalid)
				offset <= mst_i.awaddr[LOC_ADDR_W-1:0];
		end
		if (mst_i.wvalid && (state == LR_IDLE || state == LR_WR_DATA))
			wdata_q <= mst_i.wdata;
		if (state == LR_RD_RESP)
			rdata_q <= (offset == '0) ? {{(DATA_W-PRJ_SEL_W){1'b0}}, user_prj_sel_o}
			                          : UNMAPPED_RDATA;
	end

endmodule

// ==== hdl/cfg_ctrl.sv ====
`timescale 1ns/1ps

module cfg_ctrl
	import cfg_ctrl_pkg::*;
(
	input  logic                 axi_clk,
	input  logic                 axi_reset_n,

	// Configuration port
	input  logic                 aa_awvalid_i,
	input  logic [ADDR_W-1:0]    aa_awaddr_i,
	input  logic                 aa_wvalid_i,
	input  logic [DATA_W-1:0]    aa_wdata_i,
	input  logic                 aa_arvalid_i,
	input  logic [ADDR_W-1:0]    aa_araddr_i,
	input  logic                 aa_rready_i,
	output logic                 aa_awready_o,
	output logic                 aa_wready_o,
	output logic                 aa_arready_o,
	output logic [DATA_W-1:0]    aa_rdata_o,
	output logic                 aa_rvalid_o,

	// AXI-Lite master to the subsystems
	output axil_mst_t            mst_o,
	input  axil_rsp_t            rsp_up_i,
	input  axil_rsp_t            rsp_la_i,
	input  axil_rsp_t            rsp_aa_i,
	input  axil_rsp_t            rsp_is_i,

	// Target selection
	output logic                 cc_up_enable_o,
	output logic                 cc_la_enable_o,
	output logic                 cc_aa_enable_o,
	output logic                 cc_is_enable_o,
	output logic [PRJ_SEL_W-1:0] user_prj_sel_o
);

	cfg_req_t          req;
	logic              done;
	logic [DATA_W-1:0] mst_rdata;
	axil_rsp_t         rsp;        // Merged response to the master
	axil_rsp_t         rsp_loc;
	cfg_sel_t          sel;

	assign cc_up_enable_o = sel.up;
	assign cc_la_enable_o = sel.la;
	assign cc_aa_enable_o = sel.aa;
	assign cc_is_enable_o = sel.is;

	cfg_front_end u_front_end (
		.axi_clk      (axi_clk),
		.axi_reset_n  (axi_reset_n),
		.aa_awvalid_i (aa_awvalid_i),
		.aa_awaddr_i  (aa_awaddr_i),
		.aa_wvalid_i  (aa_wvalid_i),
		.aa_wdata_i   (aa_wdata_i),
		.aa_arvalid_i (aa_arvalid_i),
		.aa_araddr_i  (aa_araddr_i),
		.aa_rready_i  (aa_rready_i),
		.aa_awready_o (aa_awready_o),
		.aa_wready_o  (aa_wready_o),
		.aa_arready_o (aa_arready_o),
		.aa_rdata_o   (aa_rdata_o),
		.aa_rvalid_o  (aa_rvalid_o),
		.req_o        (req),
		.done_i       (done),
		.rdata_i      (mst_rdata)
	);

	cfg_axil_master u_master (
		.axi_clk     (axi_clk),
		.axi_reset_n (axi_reset_n),
		.req_i       (req),
		.done_o      (done),
		.rdata_o     (mst_rdata),
		.mst_o       (mst_o),
		.rsp_i       (rsp)
	);

	cfg_target_decode u_decode (
		.addr_i    (req.addr),
		.mst_i     (mst_o),
		.rsp_up_i  (rsp_up_i),
		.rsp_la_i  (rsp_la_i),
		.rsp_aa_i  (rsp_aa_i),
		.rsp_is_i  (rsp_is_i),
		.rsp_loc_i (rsp_loc),
		.sel_o     (sel),
		.rsp_o     (rsp)
	);

	cfg_local_regs u_local_regs (
		.axi_clk        (axi_clk),
		.axi_reset_n    (axi_reset_n),
		.enable_i       (sel.loc),
		.mst_i          (mst_o),
		.rsp_o          (rsp_loc),
		.user_prj_sel_o (user_prj_sel_o)
	);

endmodule

// ==== tb/cfg_ctrl_chk.sv ====
`timescale 1ns/1ps

module cfg_ctrl_chk
	import cfg_ctrl_pkg::*;
(
	input logic                 axi_clk,
	input logic                 axi_reset_n,
	input logic                 aa_awready_i,
	input logic                 aa_wready_i,
	input logic                 aa_arready_i,
	input logic                 aa_rvalid_i,
	input logic [DATA_W-1:0]    aa_rdata_i,
	input logic                 aa_rready_i,
	input axil_mst_t            mst_i,
	input axil_rsp_t            rsp_i,      // Merged response seen by the master
	input logic [3:0]           enable_i,
	input logic [PRJ_SEL_W-1:0] user_prj_sel_i
);

	int err_cnt = 0;    // Failed assertions so far

	//////////////////////////////////////////////////////////////
	// Target selection
	//////////////////////////////////////////////////////////////
	a_enable_onehot: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
		$onehot0(enable_i))
		else begin
			$error("more than one external enable is high");
			err_cnt++;
		end

	// Port read data held under back-pressure
	a_rdata_stable: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
		aa_rvalid_i && !aa_rready_i |=> aa_rvalid_i && $stable(aa_rdata_i))
		else begin
			$error("rvalid or rdata changed while rready was low");
			err_cnt++;
		end

	//////////////////////////////////////////////////////////////
	// Master valids wait for their ready
	//////////////////////////////////////////////////////////////
	a_awvalid_hold: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
		mst_i.awvalid && !rsp_i.awready |=> mst_i.awvalid && $stable(mst_i.awaddr))
		else begin
			$error("awvalid or awaddr changed before awready");
			err_cnt++;
		end

	a_wvalid_hold: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
		mst_i.wvalid && !rsp_i.wready |=> mst_i.wvalid && $stable(mst_i.wdata))
		else begin
			$error("wvalid or wdata changed before wready");
			err_cnt++;
		end

	a_arvalid_hold: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
		mst_i.arvalid && !rsp_i.arready |=> mst_i.arvalid && $stable(mst_i.araddr))
		else begin
			$error("arvalid or araddr changed before arready");
			err_cnt++;
		end

	// First clock out of reset
	a_reset_quiet: assert property (@(posedge axi_clk)
		$rose(axi_reset_n) |-> !aa_awready_i && !aa_wready_i && !aa_arready_i
			&& !aa_rvalid_i && !mst_i.awvalid && !mst_i.wvalid && !mst_i.arvalid
			&& !mst_i.rready && (enable_i == '0) && (user_prj_sel_i == '0))
		else begin
			$error("outputs not inactive right after reset");
			err_cnt++;
		end

endmodule

bind cfg_ctrl cfg_ctrl_chk u_chk (
	.axi_clk        (axi_clk),
	.axi_reset_n    (axi_reset_n),
	.aa_awready_i   (aa_awready_o),
	.aa_wready_i    (aa_wready_o),
	.aa_arready_i   (aa_arready_o),
	.aa_rvalid_i    (aa_rvalid_o),
	.aa_rdata_i     (aa_rdata_o),
	.aa_rready_i    (aa_rready_i),
	.mst_i          (mst_o),
	.rsp_i          (rsp),
	.enable_i       ({cc_is_enable_o, cc_aa_enable_o, cc_la_enable_o, cc_up_enable_o}),
	.user_prj_sel_i (user_prj_sel_o)
);

// ==== tb/tb_cfg_ctrl.sv ====
`timescale 1ns/1ps

module tb_cfg_ctrl
	import cfg_ctrl_pkg::*;
();

	localparam int WAIT_LIMIT = 64;    // Cycles per wait

	typedef enum int {
		SIG_AWREADY, SIG_WREADY, SIG_ARREADY, SIG_RVALID, SIG_MST_RREADY
	} port_sig_e;

	logic                 axi_clk;
	logic                 axi_reset_n;
	logic                 aa_awvalid_i;
	logic [ADDR_W-1:0]    aa_awaddr_i;
	logic                 aa_wvalid_i;
	logic [DATA_W-1:0]    aa_wdata_i;
	logic                 aa_arvalid_i;
	logic [ADDR_W-1:0]    aa_araddr_i;
	logic                 aa_rready_i;
	logic                 aa_awready_o;
	logic                 aa_wready_o;
	logic                 aa_arready_o;
	logic [DATA_W-1:0]    aa_rdata_o;
	logic                 aa_rvalid_o;
	axil_mst_t            mst_o;
	axil_rsp_t            ext_rsp [4];    // up, la, aa, is
	logic                 cc_up_enable_o;
	logic                 cc_la_enable_o;
	logic                 cc_aa_enable_o;
	logic                 cc_is_enable_o;
	logic [PRJ_SEL_W-1:0] user_prj_sel_o;
	logic [3:0]           ext_en;

	integer                seed = 3369;
	string                 test_name;
	int                    test_errs;
	int                    chk_base;
	int                    tests_run;
	int                    tests_failed;
	int                    mismatches;
	logic [3:0]            en_seen;        // Sticky enables since last clear
	logic [MST_ADDR_W-1:0] awaddr_seen;
	logic [MST_ADDR_W-1:0] araddr_seen;
	logic [DATA_W-1:0]     wdata_seen;
	logic [STRB_W-1:0]     wstrb_seen;
	logic [PAGE_W-1:0]     ext_page [4];
	logic [DATA_W-1:0]     data;
	logic [ADDR_W-1:0]     addr;

	assign ext_en = {cc_is_enable_o, cc_aa_enable_o, cc_la_enable_o, cc_up_enable_o};

	cfg_ctrl DUT (.*, .rsp_up_i(ext_rsp[0]), .rsp_la_i(ext_rsp[1]),
		.rsp_aa_i(ext_rsp[2]), .rsp_is_i(ext_rsp[3]));

	initial begin
		axi_clk = 1'b0;
		forever #2 axi_clk = ~axi_clk;
	end

	// Watch the master side
	always @(posedge axi_clk) begin
		en_seen <= en_seen | ext_en;
		if (mst_o.awvalid)
			awaddr_seen <= mst_o.awaddr;
		if (mst_o.arvalid)
			araddr_seen <= mst_o.araddr;
		if (mst_o.wvalid) begin
			wdata_seen <= mst_o.wdata;
			wstrb_seen <= mst_o.wstrb;
		end
	end

	//////////////////////////////////////////////////////////////
	// External subsystem models
	//////////////////////////////////////////////////////////////
	task automatic serve_target(input int idx, input logic [PAGE_W-1:0] page);
		int                    d_a;
		int                    d_b;
		int                    last;
		logic [LOC_ADDR_W-1:0] offset;
		forever begin
			@(posedge axi_clk);
			d_a = {$random(seed)} % 4;
			d_b = {$random(seed)} % 4;
			if (ext_en[idx] && mst_o.arvalid) begin
				offset = mst_o.araddr[LOC_ADDR_W-1:0];
				repeat (d_a) @(posedge axi_clk);
				ext_rsp[idx].arready <= 1'b1;
				@(posedge axi_clk);
				ext_rsp[idx].arready <= 1'b0;
				repeat (d_b) @(posedge axi_clk);
				ext_rsp[idx].rdata  <= {page, offset};    // Model word
				ext_rsp[idx].rvalid <= 1'b1;
				@(posedge axi_clk);
				ext_rsp[idx].rvalid <= 1'b0;
				ext_rsp[idx].rdata  <= '0;
			end else if (ext_en[idx] && mst_o.awvalid) begin
				last = (d_a > d_b) ? d_a : d_b;
				for (int cyc = 0; cyc <= last; cyc++) begin
					ext_rsp[idx].awready <= (cyc == d_a);
					ext_rsp[idx].wready  <= (cyc == d_b);
					@(posedge axi_clk);
				end
				ext_rsp[idx].awready <= 1'b0;
				ext_rsp[idx].wready  <= 1'b0;
			end
		end
	endtask

	initial serve_target(0, PAGE_UP);
	initial serve_target(1, PAGE_LA);
	initial serve_target(2, PAGE_AA);
	initial serve_target(3, PAGE_IS);

	//////////////////////////////////////////////////////////////
	// Checks and bookkeeping
	//////////////////////////////////////////////////////////////
	task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp)
		else begin
			$display("mismatch %s: %s expected %h actual %h", test_name, what, exp, act);
			test_errs++;
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errs = 0;
		chk_base  = DUT.u_chk.err_cnt;
	endtask

	task automatic end_test();
		int chk_errs;
		chk_errs = DUT.u_chk.err_cnt - chk_base;
		tests_run++;
		mismatches += test_errs;
		if (test_errs == 0 && chk_errs == 0) begin
			$display("test %s: ok", test_name);
		end else begin
			$display("test %s: failed, %0d mismatches, %0d assertion failures",
				test_name, test_errs, chk_errs);
			tests_failed++;
		end
	endtask

	task automatic timed_out(input string what);
		$display("timeout in test %s while waiting for %s", test_name, what);
		$display("=== FAIL ===");
		$finish;
	endtask

	function automatic logic probe(input port_sig_e sig);
		case (sig)
			SIG_AWREADY: probe = aa_awready_o;
			SIG_WREADY:  probe = aa_wready_o;
			SIG_ARREADY: probe = aa_arready_o;
			SIG_RVALID:  probe = aa_rvalid_o;
			default:     probe = mst_o.rready;
		endcase
	endfunction

	task automatic wait_level(input port_sig_e sig, input logic level, input string what);
		int cnt;
		cnt = 0;
		do begin
			@(posedge axi_clk);
			cnt++;
		end while (probe(sig) !== level && cnt < WAIT_LIMIT);
		if (probe(sig) !== level)
			timed_out(what);
	endtask

	task automatic clear_seen();
		@(negedge axi_clk);
		en_seen = '0;
	endtask

	//////////////////////////////////////////////////////////////
	// Port transfers
	//////////////////////////////////////////////////////////////
	task automatic port_write(input logic [ADDR_W-1:0] waddr, input logic [DATA_W-1:0] wdata);
		@(posedge axi_clk);
		aa_awvalid_i <= 1'b1;
		aa_awaddr_i  <= waddr;
		aa_wvalid_i  <= 1'b1;
		aa_wdata_i   <= wdata;
		wait_level(SIG_AWREADY, 1'b1, "awready");
		aa_awvalid_i <= 1'b0;
		wait_level(SIG_WREADY, 1'b1, "wready");
		aa_wvalid_i <= 1'b0;
	endtask

	task automatic port_read(input logic [ADDR_W-1:0] raddr, output logic [DATA_W-1:0] rdata);
		@(posedge axi_clk);
		aa_arvalid_i <= 1'b1;
		aa_araddr_i  <= raddr;
		aa_rready_i  <= 1'b1;
		wait_level(SIG_ARREADY, 1'b1, "arready");
		aa_arvalid_i <= 1'b0;
		wait_level(SIG_RVALID, 1'b1, "rvalid");
		rdata = aa_rdata_o;
	endtask

	// Read with rready held low before and after rvalid rises
	task automatic stalled_read(input logic [ADDR_W-1:0] raddr, input int stall,
		output logic [DATA_W-1:0] rdata);
		@(posedge axi_clk);
		aa_arvalid_i <= 1'b1;
		aa_araddr_i  <= raddr;
		aa_rready_i  <= 1'b0;
		wait_level(SIG_ARREADY, 1'b1, "arready");
		aa_arvalid_i <= 1'b0;
		wait_level(SIG_MST_RREADY, 1'b1, "master rready to rise");
		wait_level(SIG_MST_RREADY, 1'b0, "master read to finish");
		repeat (stall) begin
			@(posedge axi_clk);
			check_eq("rvalid while rready low", 32'd0, aa_rvalid_o);
		end
		aa_rready_i <= 1'b1;
		@(posedge axi_clk);
		aa_rready_i <= 1'b0;
		wait_level(SIG_RVALID, 1'b1, "rvalid");
		rdata = aa_rdata_o;
		repeat (stall) begin
			@(posedge axi_clk);
			check_eq("rvalid held", 32'd1, aa_rvalid_o);
			check_eq("rdata held", rdata, aa_rdata_o);
		end
		aa_rready_i <= 1'b1;
		wait_level(SIG_RVALID, 1'b0, "rvalid to fall");
	endtask

	//////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////
	initial begin
		axi_reset_n  = 1'b0;
		aa_awvalid_i = 1'b0;
		aa_awaddr_i  = '0;
		aa_wvalid_i  = 1'b0;
		aa_wdata_i   = '0;
		aa_arvalid_i = 1'b0;
		aa_araddr_i  = '0;
		aa_rready_i  = 1'b0;
		en_seen      = '0;
		tests_run    = 0;
		tests_failed = 0;
		mismatches   = 0;
		for (int k = 0; k < 4; k++)
			ext_rsp[k] = '0;
		ext_page[0] = PAGE_UP;
		ext_page[1] = PAGE_LA;
		ext_page[2] = PAGE_AA;
		ext_page[3] = PAGE_IS;

		repeat (2) @(posedge axi_clk);
		axi_reset_n <= 1'b1;

		start_test("reset_state");
		@(posedge axi_clk);
		check_eq("awready", 32'd0, aa_awready_o);
		check_eq("wready", 32'd0, aa_wready_o);
		check_eq("arready", 32'd0, aa_arready_o);
		check_eq("rvalid", 32'd0, aa_rvalid_o);
		check_eq("master valids", 32'd0,
			{mst_o.awvalid, mst_o.wvalid, mst_o.arvalid, mst_o.rready});
		check_eq("enables", 32'd0, ext_en);
		check_eq("user_prj_sel", 32'd0, user_prj_sel_o);
		end_test();

		start_test("local_write_read");
		port_write(32'h3000_4000, 32'h0000_001B);
		check_eq("user_prj_sel", 32'h1B, user_prj_sel_o);
		port_read(32'h3000_4000, data);
		check_eq("rdata", 32'h0000_001B, data);
		end_test();

		start_test("local_other_offset");
		port_read(32'h3000_4004, data);
		check_eq("rdata", 32'hFFFF_FFFF, data);
		check_eq("user_prj_sel", 32'h1B, user_prj_sel_o);
		end_test();

		start_test("unmapped_range");
		clear_seen();
		port_write(32'h3000_7010, $random(seed));
		port_read(32'h3000_7010, data);
		check_eq("rdata", 32'hFFFF_FFFF, data);
		check_eq("external enables", 32'd0, en_seen);
		end_test();

		for (int k = 0; k < 4; k++) begin
			start_test($sformatf("external_page_%0d", k));
			addr = {ext_page[k], 12'h010 + 12'(4 * k)};
			data = $random(seed);
			clear_seen();
			port_write(addr, data);
			check_eq("write enables", 32'd1 << k, en_seen);
			check_eq("awaddr", addr[MST_ADDR_W-1:0], awaddr_seen);
			check_eq("wdata", data, wdata_seen);
			check_eq("wstrb", 32'hF, wstrb_seen);
			clear_seen();
			port_read(addr, data);
			check_eq("read enables", 32'd1 << k, en_seen);
			check_eq("araddr", addr[MST_ADDR_W-1:0], araddr_seen);
			check_eq("rdata", addr, data);    // Page number with offset below
			end_test();
		end

		start_test("read_backpressure");
		stalled_read(32'h3000_2048, 5, data);
		check_eq("rdata", 32'h3000_2048, data);
		end_test();

		repeat (2) @(posedge axi_clk);
		$display("tests run %0d, failed %0d, mismatches %0d, assertion failures %0d",
			tests_run, tests_failed, mismatches, DUT.u_chk.err_cnt);
		if (tests_failed == 0 && mismatches == 0 && DUT.u_chk.err_cnt == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// ==== all.f ====
hdl/cfg_ctrl_pkg.sv
hdl/cfg_front_end.sv
hdl/cfg_axil_master.sv
hdl/cfg_target_decode.sv
hdl/cfg_local_regs.sv
hdl/cfg_ctrl.sv
tb/cfg_ctrl_chk.sv
tb/tb_cfg_ctrl.sv

// ==== Bender.yml ====
package:
  name: cfg_ctrl

sources:
  - hdl/cfg_ctrl_pkg.sv
  - hdl/cfg_front_end.sv
  - hdl/cfg_axil_master.sv
  - hdl/cfg_target_decode.sv
  - hdl/cfg_local_regs.sv
  - hdl/cfg_ctrl.sv
  - target: simulation
    files:
      - tb/cfg_ctrl_chk.sv
      - tb/tb_cfg_ctrl.sv
